//--- src/fgp_rx_defines.svh
// FGP receive constants
`ifndef FGP_RX_DEFINES_SVH
`define FGP_RX_DEFINES_SVH

// Ethernet framing
`define ETH_PREAMBLE_BYTE 8'h55
`define ETH_SFD 8'hD5
`define ETH_HEADER_LEN 14

// Frame graphics protocol
`define FGP_ETHERTYPE 16'h88B5
`define FGP_DATA_LEN 48
`define COLORS_PER_FRAME 32

// Video cache RAM geometry
`define VRAM_ADDR_LEN 10
`define COLOR_LEN 12

`endif

//--- src/fgp_rx_pkg.sv
// FGP receive types
`default_nettype none

`include "fgp_rx_defines.svh"

package fgp_rx_pkg;

	typedef logic [1:0] dibit_t;
	typedef logic [7:0] byte_t;
	typedef logic [15:0] ethertype_t;
	// 4 bits each of red, green and blue
	typedef logic [`COLOR_LEN-1:0] color_t;
	typedef logic [`VRAM_ADDR_LEN-1:0] vram_addr_t;
	// Selects one of 32 blocks of colors
	typedef logic [4:0] fgp_offset_t;
	typedef logic [3:0] header_count_t;
	typedef logic [5:0] data_count_t;

	typedef enum logic [1:0] {asm_idle, asm_preamble, asm_data} assembler_state_e;
	typedef enum logic [1:0] {filt_header, filt_pass, filt_drop} filter_state_e;
	typedef enum logic [1:0] {parse_offset, parse_data, parse_done} parser_state_e;

endpackage

`default_nettype wire

//--- src/fgp_stream_ifs.sv
// Receive stream interfaces
`default_nettype none

// Byte stream, one byte per valid pulse, no back-pressure
interface byte_stream_if import fgp_rx_pkg::*; ();

	logic valid;
	byte_t data;
	// High with valid on the first byte of a frame
	logic first;
	// Pulse without valid at the end of a frame
	logic frame_end;

	modport src (output valid, data, first, frame_end);
	modport sink (input valid, data, first, frame_end);

endinterface

// Parsed FGP stream
interface fgp_stream_if import fgp_rx_pkg::*; ();

	// Pulse with the block offset of the frame
	logic setoff;
	fgp_offset_t offset;
	// Pulse per pixel data byte
	logic valid;
	byte_t data;
	logic frame_end;

	modport src (output setoff, offset, valid, data, frame_end);
	modport sink (input setoff, offset, valid, data, frame_end);

endinterface

`default_nettype wire

//--- src/rmii_dibit_assembler.sv
// RMII dibit to byte assembly
`default_nettype none

`include "fgp_rx_defines.svh"

module rmii_dibit_assembler import fgp_rx_pkg::*; (
	input logic clk,
	input logic eth_rx_downstream_rst,
	input logic crs_dv,
	input dibit_t rxd,
	byte_stream_if.src out
);

	assembler_state_e state;
	byte_t shift_reg;
	byte_t shift_next;
	logic [1:0] dibit_cnt;
	logic first_pending;

	// Dibits arrive least significant first
	assign shift_next = {rxd, shift_reg[7:2]};

	always_ff @(posedge clk) begin
		out.valid <= 1'b0;
		out.first <= 1'b0;
		out.frame_end <= 1'b0;
		if (eth_rx_downstream_rst) begin
			state <= asm_idle;
			dibit_cnt <= '0;
			first_pending <= 1'b0;
		end else begin
			case (state)
				asm_idle: begin
					// Start from a clean window so stale bits cannot fake a delimiter
					if (crs_dv) begin
						shift_reg <= {rxd, 6'b000000};
						state <= asm_preamble;
					end
				end
				asm_preamble: begin
					if (!crs_dv) begin
						state <= asm_idle;
					end else begin
						shift_reg <= shift_next;
						if (shift_next == `ETH_SFD) begin
							state <= asm_data;
							dibit_cnt <= '0;
							first_pending <= 1'b1;
						end
					end
				end
				default: begin
					if (!crs_dv) begin
						// Partial byte is dropped with the frame end
						out.frame_end <= 1'b1;
						state <= asm_idle;
					end else begin
						shift_reg <= shift_next;
						dibit_cnt <= dibit_cnt + 2'd1;
						if (dibit_cnt == 2'd3) begin
							out.valid <= 1'b1;
							out.data <= shift_next;
							out.first <= first_pending;
							first_pending <= 1'b0;
						end
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/ethertype_filter.sv
// Ethernet header strip and ethertype filter
`default_nettype none

`include "fgp_rx_defines.svh"

module ethertype_filter import fgp_rx_pkg::*; (
	input logic clk,
	input logic eth_rx_downstream_rst,
	byte_stream_if.sink in,
	byte_stream_if.src out
);

	filter_state_e state;
	header_count_t hdr_cnt;
	header_count_t byte_idx;
	ethertype_t ethertype;
	logic first_pending;

	// A first byte always restarts the header count
	assign byte_idx = in.first ? '0 : hdr_cnt;

	always_ff @(posedge clk) begin
		out.valid <= 1'b0;
		out.first <= 1'b0;
		out.frame_end <= 1'b0;
		if (eth_rx_downstream_rst) begin
			state <= filt_header;
			hdr_cnt <= '0;
			first_pending <= 1'b0;
		end else if (in.frame_end) begin
			out.frame_end <= (state == filt_pass);
			state <= filt_header;
			hdr_cnt <= '0;
		end else if (in.valid) begin
			if (in.first || state == filt_header) begin
				state <= filt_header;
				hdr_cnt <= byte_idx + 4'd1;
				// Ethertype is big-endian in bytes 12 and 13
				if (byte_idx >= header_count_t'(`ETH_HEADER_LEN - 2)) begin
					ethertype <= {ethertype[7:0], in.data};
				end
				if (byte_idx == header_count_t'(`ETH_HEADER_LEN - 1)) begin
					if ({ethertype[7:0], in.data} == `FGP_ETHERTYPE) begin
						state <= filt_pass;
						first_pending <= 1'b1;
					end else begin
						state <= filt_drop;
					end
				end
			end else if (state == filt_pass) begin
				out.valid <= 1'b1;
				out.data <= in.data;
				out.first <= first_pending;
				first_pending <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/fgp_parser.sv
// FGP offset and data split
`default_nettype none

`include "fgp_rx_defines.svh"

module fgp_parser import fgp_rx_pkg::*; (
	input logic clk,
	input logic eth_rx_downstream_rst,
	byte_stream_if.sink in,
	fgp_stream_if.src out
);

	parser_state_e state;
	data_count_t data_cnt;

	always_ff @(posedge clk) begin
		out.setoff <= 1'b0;
		out.valid <= 1'b0;
		out.frame_end <= 1'b0;
		if (eth_rx_downstream_rst) begin
			state <= parse_offset;
			data_cnt <= '0;
		end else if (in.frame_end) begin
			out.frame_end <= 1'b1;
			state <= parse_offset;
		end else if (in.valid) begin
			if (in.first || state == parse_offset) begin
				// Only the low bits pick a block
				out.setoff <= 1'b1;
				out.offset <= in.data[4:0];
				data_cnt <= '0;
				state <= parse_data;
			end else if (state == parse_data) begin
				out.valid <= 1'b1;
				out.data <= in.data;
				data_cnt <= data_cnt + 6'd1;
				if (data_cnt == data_count_t'(`FGP_DATA_LEN - 1)) begin
					state <= parse_done;
				end
			end
			// Trailing bytes such as the FCS fall through here
		end
	end

endmodule

`default_nettype wire

//--- src/color_writer.sv
// Byte triple to color packing
`default_nettype none

`include "fgp_rx_defines.svh"

module color_writer import fgp_rx_pkg::*; (
	input logic clk,
	input logic eth_rx_downstream_rst,
	fgp_stream_if.sink in,
	output logic ram_we,
	output vram_addr_t ram_addr,
	output color_t ram_color
);

	vram_addr_t wr_addr;
	logic [1:0] phase;
	byte_t byte0;
	logic [3:0] byte1_high;

	always_ff @(posedge clk) begin
		ram_we <= 1'b0;
		if (eth_rx_downstream_rst) begin
			wr_addr <= '0;
			phase <= '0;
		end else if (in.setoff) begin
			wr_addr <= vram_addr_t'(in.offset) * vram_addr_t'(`COLORS_PER_FRAME);
			phase <= '0;
		end else if (in.frame_end) begin
			// Unfinished triple is discarded
			phase <= '0;
		end else if (in.valid) begin
			case (phase)
				2'd0: begin
					byte0 <= in.data;
					phase <= 2'd1;
				end
				2'd1: begin
					// Color 0 is low nibble of b1 above b0
					ram_we <= 1'b1;
					ram_addr <= wr_addr;
					ram_color <= {in.data[3:0], byte0};
					byte1_high <= in.data[7:4];
					wr_addr <= wr_addr + vram_addr_t'(1);
					phase <= 2'd2;
				end
				default: begin
					// Color 1 is b2 above high nibble of b1
					ram_we <= 1'b1;
					ram_addr <= wr_addr;
					ram_color <= {in.data, byte1_high};
					wr_addr <= wr_addr + vram_addr_t'(1);
					phase <= 2'd0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/video_cache_ram.sv
// Video cache RAM with Wishbone read
`default_nettype none

module video_cache_ram import fgp_rx_pkg::*; (
	input logic clk,
	input logic eth_rx_downstream_rst,
	input logic ram_we,
	input vram_addr_t ram_addr,
	input color_t ram_color,
	input logic wb_cyc,
	input logic wb_stb,
	input vram_addr_t wb_adr,
	output color_t wb_data,
	output logic wb_ack
);

	color_t mem [0:(1 << $bits(vram_addr_t)) - 1];
	logic wb_req;
	// Request already answered, waiting for stb to drop
	logic served;

	assign wb_req = wb_cyc && wb_stb;

	always_ff @(posedge clk) begin
		if (ram_we) begin
			mem[ram_addr] <= ram_color;
		end
	end

	// Read port runs regardless of writes
	always_ff @(posedge clk) begin
		wb_data <= mem[wb_adr];
	end

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			wb_ack <= 1'b0;
			served <= 1'b0;
		end else begin
			wb_ack <= wb_req && !served;
			served <= wb_req;
		end
	end

endmodule

`default_nettype wire

//--- src/fgp_rx_top.sv
// FGP receive top level
`default_nettype none

module fgp_rx_top import fgp_rx_pkg::*; (
	input logic clk,
	input logic eth_rx_downstream_rst,
	input logic crs_dv,
	input logic [1:0] rxd,
	input logic wb_cyc,
	input logic wb_stb,
	input logic [9:0] wb_adr,
	output logic [11:0] wb_data,
	output logic wb_ack
);

	byte_stream_if asm_bytes ();
	byte_stream_if payload ();
	fgp_stream_if fgp_bytes ();

	logic ram_we;
	vram_addr_t ram_addr;
	color_t ram_color;

	// RMII dibits to framed bytes
	rmii_dibit_assembler u_assembler (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.crs_dv(crs_dv),
		.rxd(rxd),
		.out(asm_bytes.src)
	);

	ethertype_filter u_filter (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.in(asm_bytes.sink),
		.out(payload.src)
	);

	fgp_parser u_parser (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.in(payload.sink),
		.out(fgp_bytes.src)
	);

	color_writer u_writer (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.in(fgp_bytes.sink),
		.ram_we(ram_we),
		.ram_addr(ram_addr),
		.ram_color(ram_color)
	);

	video_cache_ram u_vram (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.ram_we(ram_we),
		.ram_addr(ram_addr),
		.ram_color(ram_color),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_adr(wb_adr),
		.wb_data(wb_data),
		.wb_ack(wb_ack)
	);

endmodule

`default_nettype wire

//--- tests/fgp_frame_tasks.svh
// FGP frame and Wishbone tasks
`ifndef FGP_FRAME_TASKS_SVH
`define FGP_FRAME_TASKS_SVH

task automatic fail_run(input string why);
	$display("%s", why);
	$display("Result: FAILED");
	$fatal(1, "test stopped");
endtask

task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
	if (actual !== expected) begin
		fail_run($sformatf("FAILED at time %0t: %s, got %h, expected %h",
			$time, what, actual, expected));
	end
endtask

task automatic idle_cycles(input int n);
	crs_dv = 1'b0;
	repeat (n) begin
		@(posedge clk);
		#1;
	end
endtask

// Classic single read, stb held until ack
task automatic wb_read(input logic [9:0] adr, output logic [11:0] data);
	int waited;
	waited = 0;
	wb_cyc = 1'b1;
	wb_stb = 1'b1;
	wb_adr = adr;
	@(posedge clk);
	#1;
	while (!wb_ack) begin
		waited++;
		if (waited >= ack_timeout) begin
			fail_run($sformatf("No Wishbone ack came for the read of address %0d", adr));
		end
		@(posedge clk);
		#1;
	end
	data = wb_data;
	wb_cyc = 1'b0;
	wb_stb = 1'b0;
	@(posedge clk);
	#1;
endtask

// stop_at and rst_at count dibits from the first pixel data byte, -1 for none
task automatic send_frame(input logic [15:0] etype, input logic [7:0] offset,
		input int stop_at, input int rst_at);
	logic [7:0] bytes [$];
	logic [7:0] cur;
	logic [31:0] r;
	int start;
	int total;
	r = $random(seed);
	for (int i = 0; i < 3 + int'(r[3:0]) % 10; i++) begin
		bytes.push_back(`ETH_PREAMBLE_BYTE);
	end
	bytes.push_back(`ETH_SFD);
	// Destination and source MAC
	for (int i = 0; i < 12; i++) begin
		bytes.push_back(8'($random(seed)));
	end
	bytes.push_back(etype[15:8]);
	bytes.push_back(etype[7:0]);
	bytes.push_back(offset);
	start = 4 * bytes.size();
	for (int i = 0; i < 48; i++) begin
		bytes.push_back(data_bytes[i]);
	end
	// Stand-in for the FCS
	for (int i = 0; i < 4; i++) begin
		bytes.push_back(8'($random(seed)));
	end
	total = (stop_at >= 0) ? start + stop_at : 4 * bytes.size();
	for (int d = 0; d < total; d++) begin
		cur = bytes[d / 4];
		crs_dv = 1'b1;
		rxd = 2'(cur >> (2 * (d % 4)));
		if (rst_at >= 0) begin
			eth_rx_downstream_rst = (d >= start + rst_at) && (d < start + rst_at + 2);
			// A read request held during the reset must not be acked
			wb_cyc = eth_rx_downstream_rst;
			wb_stb = eth_rx_downstream_rst;
		end
		@(posedge clk);
		#1;
		if (rst_at >= 0 && d >= start + rst_at) begin
			check_equal(32'(wb_ack), 0, "wb_ack low from the reset on");
		end
	end
	eth_rx_downstream_rst = 1'b0;
	wb_cyc = 1'b0;
	wb_stb = 1'b0;
	idle_cycles(1 + int'(r[7:4]) % 7);
endtask

`endif

//--- tests/tb_fgp_rx.sv
// FGP receive testbench
`default_nettype none

`include "fgp_rx_defines.svh"

module tb_fgp_rx;

	localparam int ack_timeout = 16;
	// Receive latency is 4 cycles, a little margin on top
	localparam int drain_cycles = 6;

	logic clk;
	logic eth_rx_downstream_rst;
	logic crs_dv;
	logic [1:0] rxd;
	logic wb_cyc;
	logic wb_stb;
	logic [9:0] wb_adr;
	logic [11:0] wb_data;
	logic wb_ack;
	integer seed;
	logic [7:0] data_bytes [];
	// Expected video RAM, written marks entries with a known color
	logic [11:0] exp_mem [];
	bit written [];

	fgp_rx_top dut (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.crs_dv(crs_dv),
		.rxd(rxd),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_adr(wb_adr),
		.wb_data(wb_data),
		.wb_ack(wb_ack)
	);

	`include "fgp_frame_tasks.svh"

	initial begin
		clk = 1'b0;
		forever begin
			#2;
			clk = ~clk;
		end
	end

	// Two colors per byte triple, only from the first kept data bytes
	task automatic update_model(input logic [7:0] offset, input int kept);
		logic [9:0] a;
		for (int i = 0; i < 16; i++) begin
			a = {offset[4:0], 5'd0} + 10'(2 * i);
			if (3 * i + 1 < kept) begin
				exp_mem[a] = {data_bytes[3 * i + 1][3:0], data_bytes[3 * i]};
				written[a] = 1'b1;
			end
			if (3 * i + 2 < kept) begin
				exp_mem[a + 10'd1] = {data_bytes[3 * i + 2], data_bytes[3 * i + 1][7:4]};
				written[a + 10'd1] = 1'b1;
			end
		end
	endtask

	task automatic check_range(input int lo, input int count);
		logic [11:0] got;
		for (int a = lo; a < lo + count; a++) begin
			if (written[a]) begin
				wb_read(10'(a), got);
				check_equal(32'(got), 32'(exp_mem[a]), $sformatf("color at address %0d", a));
			end
		end
	endtask

	initial begin
		logic [31:0] r;
		logic [15:0] etype;
		int cut;
		int kept;
		int kind;
		seed = 32'h8979;
		eth_rx_downstream_rst = 1'b1;
		crs_dv = 1'b0;
		rxd = 2'b00;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_adr = '0;
		data_bytes = new[48];
		exp_mem = new[1024];
		written = new[1024];
		repeat (2) begin
			@(posedge clk);
		end
		#1;
		eth_rx_downstream_rst = 1'b0;
		// Give every address a known color first
		for (int b = 0; b < 32; b++) begin
			for (int i = 0; i < 48; i++) begin
				data_bytes[i] = 8'($random(seed));
			end
			send_frame(`FGP_ETHERTYPE, 8'(b), -1, -1);
			idle_cycles(drain_cycles);
			update_model(8'(b), 48);
			check_range(0, 1024);
		end
		for (int f = 0; f < 32; f++) begin
			kind = f % 8;
			r = $random(seed);
			for (int i = 0; i < 48; i++) begin
				data_bytes[i] = 8'($random(seed));
			end
			cut = int'(r[15:8]) % 192;
			etype = `FGP_ETHERTYPE;
			kept = 48;
			if (kind == 0) begin
				etype = (r[31:16] == `FGP_ETHERTYPE) ? 16'h0800 : r[31:16];
				kept = 0;
				send_frame(etype, r[7:0], -1, -1);
			end else if (kind == 3) begin
				// Carrier drops after cut dibits of pixel data
				kept = cut / 4;
				send_frame(etype, r[7:0], cut, -1);
			end else if (kind == 6) begin
				// Reset comes with the first dibit after data byte kept
				kept = 1 + cut % 46;
				send_frame(etype, r[7:0], -1, 4 * (kept + 1));
			end else begin
				send_frame(etype, r[7:0], -1, -1);
			end
			idle_cycles(drain_cycles);
			update_model(r[7:0], kept);
			if (kind == 0 || kind == 3 || kind == 6) begin
				check_range(0, 1024);
			end else begin
				check_range(32 * int'(r[4:0]), 32);
			end
		end
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
+incdir+src
+incdir+tests
src/fgp_rx_pkg.sv
src/fgp_stream_ifs.sv
src/rmii_dibit_assembler.sv
src/ethertype_filter.sv
src/fgp_parser.sv
src/color_writer.sv
src/video_cache_ram.sv
src/fgp_rx_top.sv
tests/tb_fgp_rx.sv

//--- run.sh
#!/bin/sh
# Build and run the FGP receive testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_fgp_rx -f all.f -o tb_fgp_rx
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/tb_fgp_rx
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation ended with status $status"
	exit $status
fi
exit 0
